// File: vlog.f
+incdir+sim
logic/pool_pkg.sv
logic/pool_frame_ctrl.sv
logic/pool_row_buffer.sv
logic/pool_compare.sv
logic/pool_write.sv
logic/max_pool_top.sv
sim/tb_max_pool.sv

// File: run.sh
#!/bin/sh
# Build and run the max-pool testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_max_pool -f vlog.f -o tb_max_pool

# The run status is judged from the log below
./obj_dir/tb_max_pool > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
    echo "Simulation did not complete"
    exit 1
fi
echo "Simulation PASSED"

// File: sim/tb_checks.svh
// Max-pool testbench compare tasks, frame helpers and directed tests
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

    //====================================================================
    // Compare tasks
    //====================================================================
    task automatic check_pixel(input string name, input pool_pkg::pixel_t got,
                               input pool_pkg::pixel_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR at %0t ns: %s = 0x%h, expected 0x%h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input pool_pkg::addr_t got,
                              input pool_pkg::addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR at %0t ns: %s = %0d, expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR at %0t ns: %s = %b, expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("ERROR at %0t ns: %s = %0d, expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    //====================================================================
    // Frame helpers
    //====================================================================
    task automatic issue_run();
        @(posedge clk);
        i_run <= 1'b1;
    endtask

    // One beat per cycle and run raised again on beat err_beat or never for -1
    task automatic stream_frame(input int err_beat);
        @(posedge clk);
        frame_writes = 0;
        for (int i = 0; i < NUM_PIX; i++) begin
            i_run      <= (i == err_beat);
            i_in_valid <= 1'b1;
            i_pixel    <= frame_pix[i];
            @(posedge clk);
        end
        i_run      <= 1'b0;
        i_in_valid <= 1'b0;
    endtask

    // Returns on the edge right after the last write, which enters S_DONE
    task automatic wait_last_write();
        int cycles;
        cycles = 0;
        // Frame still busy while the pipeline drains
        @(negedge clk);
        check_flag("o_run", o_run, 1'b1);
        check_flag("o_idle", o_idle, 1'b0);
        while (frame_writes < pool_pkg::POOL_WORDS) begin
            @(posedge clk);
            cycles++;
            if (cycles > 40) begin
                report_failure("Timed out waiting for the last pooled write of the frame");
            end
        end
    endtask

    task automatic compare_frame();
        for (int a = 0; a < pool_pkg::POOL_WORDS; a++) begin
            check_addr($sformatf("o_mem.addr of write %0d", a), wr_addr_log[a],
                       pool_pkg::addr_t'(a));
            check_pixel($sformatf("o_mem.data at addr %0d", a), scoreboard[a], expected[a]);
        end
    endtask

    // Rerun issues the next run during the done cycle
    task automatic finish_frame(input bit rerun);
        wait_last_write();
        if (rerun) begin
            i_run <= 1'b1;
        end
        @(negedge clk);
        check_flag("o_done", o_done, 1'b1);
        check_count("writes in frame", frame_writes, pool_pkg::POOL_WORDS);
        compare_frame();
        if (!rerun) begin
            @(negedge clk);
            check_flag("o_done", o_done, 1'b0);
            check_flag("o_idle", o_idle, 1'b1);
        end
    endtask

    //====================================================================
    // Directed tests
    //====================================================================
    task automatic after_reset_quiet();
        @(negedge clk);
        check_flag("o_idle", o_idle, 1'b1);
        check_flag("o_run", o_run, 1'b0);
        check_flag("o_done", o_done, 1'b0);
        check_flag("o_en_err", o_en_err, 1'b0);
        repeat (8) begin
            @(negedge clk);
            check_flag("o_mem.ce", o_mem.ce, 1'b0);
        end
    endtask

    task automatic ramp_frame();
        fill_ramp();
        compute_expected();
        issue_run();
        stream_frame(-1);
        finish_frame(1'b0);
    endtask

    task automatic random_frame();
        fill_random();
        compute_expected();
        issue_run();
        stream_frame(-1);
        finish_frame(1'b0);
        check_flag("o_en_err", o_en_err, 1'b0);
    endtask

    // Beats before any run must be dropped
    task automatic idle_beats_ignored();
        fill_random();
        frame_writes = 0;
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            i_in_valid <= 1'b1;
            i_pixel    <= frame_pix[i];
        end
        @(posedge clk);
        i_in_valid <= 1'b0;
        repeat (6) @(negedge clk);
        check_count("writes while idle", frame_writes, 0);
        compute_expected();
        issue_run();
        stream_frame(-1);
        finish_frame(1'b0);
    endtask

    task automatic run_mid_frame();
        fill_random();
        compute_expected();
        issue_run();
        stream_frame(29);
        finish_frame(1'b0);
        check_flag("o_en_err", o_en_err, 1'b1);
        // Sticky over a clean frame
        fill_random();
        compute_expected();
        issue_run();
        stream_frame(-1);
        finish_frame(1'b0);
        check_flag("o_en_err", o_en_err, 1'b1);
    endtask

    task automatic back_to_back_frames();
        fill_random();
        compute_expected();
        issue_run();
        stream_frame(-1);
        finish_frame(1'b1);
        fill_random();
        compute_expected();
        stream_frame(-1);
        finish_frame(1'b0);
        check_flag("o_en_err", o_en_err, 1'b1);
    endtask

`endif

// File: sim/tb_max_pool.sv
// Max-pool testbench top with clock, reset, watchdog, reference model and test sequence
`timescale 1ns/1ns

module tb_max_pool;

    //====================================================================
    // Run limits
    //====================================================================
    localparam int NUM_TESTS   = 6;
    // Worst case test streams two frames
    localparam int MAX_FRAMES  = 2;
    localparam int CLK_PERIOD  = 20;
    localparam int NUM_PIX     = pool_pkg::IMG_W * pool_pkg::IMG_H;
    localparam int WATCHDOG_NS = (NUM_TESTS * MAX_FRAMES * (NUM_PIX + 40) + 100) * CLK_PERIOD;

    logic              clk = 1'b0;
    logic              areset;
    logic              i_run;
    logic              i_in_valid;
    pool_pkg::pixel_t  i_pixel;
    logic              o_idle;
    logic              o_run;
    logic              o_done;
    logic              o_en_err;
    pool_pkg::mem_wr_t o_mem;

    // Stimulus frame and expected memory image
    integer            seed = 32'h3d9a_96c2;
    pool_pkg::pixel_t  frame_pix   [NUM_PIX];
    pool_pkg::pixel_t  expected    [pool_pkg::POOL_WORDS];
    // Scoreboard filled by the write monitor
    pool_pkg::pixel_t  scoreboard  [pool_pkg::POOL_WORDS];
    pool_pkg::addr_t   wr_addr_log [pool_pkg::POOL_WORDS];
    int                frame_writes = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    max_pool_top i_max_pool_top (
        .clk        (clk),
        .areset     (areset),
        .i_run      (i_run),
        .i_in_valid (i_in_valid),
        .i_pixel    (i_pixel),
        .o_idle     (o_idle),
        .o_run      (o_run),
        .o_done     (o_done),
        .o_en_err   (o_en_err),
        .o_mem      (o_mem)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("Watchdog expired before the test sequence finished");
    end

    // Write port sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (o_mem.ce) begin
            scoreboard[o_mem.addr] = o_mem.data;
            if (frame_writes < pool_pkg::POOL_WORDS) begin
                wr_addr_log[frame_writes] = o_mem.addr;
            end
            frame_writes = frame_writes + 1;
        end
    end

    //====================================================================
    // Reference model
    //====================================================================
    // Every channel grows with x and with y
    task automatic fill_ramp();
        for (int y = 0; y < pool_pkg::IMG_H; y++) begin
            for (int x = 0; x < pool_pkg::IMG_W; x++) begin
                for (int c = 0; c < pool_pkg::NUM_CH; c++) begin
                    frame_pix[y*pool_pkg::IMG_W + x][c*pool_pkg::CH_W +: pool_pkg::CH_W] =
                        pool_pkg::chan_t'(c*32 + 2*x + 3*y);
                end
            end
        end
    endtask

    task automatic fill_random();
        for (int p = 0; p < NUM_PIX; p++) begin
            for (int c = 0; c < pool_pkg::NUM_CH; c++) begin
                frame_pix[p][c*pool_pkg::CH_W +: pool_pkg::CH_W] =
                    pool_pkg::chan_t'($random(seed));
            end
        end
    endtask

    // Per-channel max over each 2x2 window, stored at its raster index
    task automatic compute_expected();
        pool_pkg::chan_t best;
        pool_pkg::chan_t cand;
        int              base;
        for (int oy = 0; oy < pool_pkg::OUT_H; oy++) begin
            for (int ox = 0; ox < pool_pkg::OUT_W; ox++) begin
                base = 2*oy*pool_pkg::IMG_W + 2*ox;
                for (int c = 0; c < pool_pkg::NUM_CH; c++) begin
                    best = '0;
                    for (int dy = 0; dy < 2; dy++) begin
                        for (int dx = 0; dx < 2; dx++) begin
                            cand = frame_pix[base + dy*pool_pkg::IMG_W + dx]
                                            [c*pool_pkg::CH_W +: pool_pkg::CH_W];
                            if (cand > best) begin
                                best = cand;
                            end
                        end
                    end
                    expected[oy*pool_pkg::OUT_W + ox][c*pool_pkg::CH_W +: pool_pkg::CH_W] = best;
                end
            end
        end
    endtask

    `include "tb_checks.svh"

    //====================================================================
    // Test sequence
    //====================================================================
    initial begin
        areset     = 1'b1;
        i_run      = 1'b0;
        i_in_valid = 1'b0;
        i_pixel    = '0;
        repeat (16) @(posedge clk);
        areset <= 1'b0;
        after_reset_quiet();
        ramp_frame();
        random_frame();
        idle_beats_ignored();
        run_mid_frame();
        back_to_back_frames();
        $display("All checks passed");
        $finish;
    end

endmodule

// File: logic/max_pool_top.sv
// Max-pool layer top wiring controller, row buffer, comparator and writer
`timescale 1ns/1ns

module max_pool_top (
    input  logic              clk,
    input  logic              areset,
    input  logic              i_run,
    input  logic              i_in_valid,
    input  pool_pkg::pixel_t  i_pixel,
    output logic              o_idle,
    output logic              o_run,
    output logic              o_done,
    output logic              o_en_err,
    output pool_pkg::mem_wr_t o_mem
);

    //====================================================================
    // Internal connections
    //====================================================================
    logic              ctrl_accept;
    logic              ctrl_start;
    logic              last_write;
    pool_pkg::pair_t   pair;
    pool_pkg::pooled_t pooled;

    // Frame control
    pool_frame_ctrl u_frame_ctrl (
        .clk          (clk),
        .areset       (areset),
        .i_run        (i_run),
        .i_last_write (last_write),
        .o_idle       (o_idle),
        .o_run        (o_run),
        .o_accept     (ctrl_accept),
        .o_start      (ctrl_start),
        .o_done       (o_done),
        .o_en_err     (o_en_err)
    );

    // Decode
    pool_row_buffer u_row_buffer (
        .clk        (clk),
        .areset     (areset),
        .i_start    (ctrl_start),
        .i_accept   (ctrl_accept),
        .i_in_valid (i_in_valid),
        .i_pixel    (i_pixel),
        .o_pair     (pair)
    );

    // Execute
    pool_compare u_compare (.clk(clk), .areset(areset), .i_pair(pair), .o_pooled(pooled));

    // Result
    pool_write u_write (
        .clk          (clk),
        .areset       (areset),
        .i_pooled     (pooled),
        .o_mem        (o_mem),
        .o_last_write (last_write)
    );

endmodule

// File: logic/pool_write.sv
// Max-pool writer mapping pooled pixels onto the block RAM port
`timescale 1ns/1ns

module pool_write (
    input  logic              clk,
    input  logic              areset,
    input  pool_pkg::pooled_t i_pooled,
    output pool_pkg::mem_wr_t o_mem,
    output logic              o_last_write
);

    // Writes issued so far in this frame
    pool_pkg::addr_t wr_cnt;
    logic            cnt_last;

    //====================================================================
    // Memory port
    //====================================================================
    // Straight from the comparator register, no extra cycle
    always_comb begin
        o_mem.ce   = i_pooled.valid;
        o_mem.addr = i_pooled.out_addr;
        o_mem.data = i_pooled.pixel;
    end

    //====================================================================
    // Frame write count
    //====================================================================
    assign cnt_last = (wr_cnt == pool_pkg::addr_t'(pool_pkg::POOL_WORDS - 1));

    always_ff @(posedge clk) begin
        if (areset) begin
            wr_cnt <= '0;
        end else if (i_pooled.valid) begin
            // Restart for the next frame
            wr_cnt <= cnt_last ? '0 : wr_cnt + 1'b1;
        end
    end

    // Together with the final word of the frame
    assign o_last_write = i_pooled.valid && cnt_last;

    // Raster order out of the row buffer means address tracks the count
    a_addr_order: assert property (@(posedge clk) disable iff (areset)
        o_mem.ce |-> (o_mem.addr == wr_cnt))
        else $error("pooled write out of raster order");

endmodule

// File: logic/pool_compare.sv
// Max-pool comparator taking the vertical then horizontal per-channel maximum
`timescale 1ns/1ns

module pool_compare (
    input  logic              clk,
    input  logic              areset,
    input  pool_pkg::pair_t   i_pair,
    output pool_pkg::pooled_t o_pooled
);

    // Vertical stage
    logic             vert_valid;
    logic             vert_odd;
    pool_pkg::addr_t  vert_addr;
    pool_pkg::pixel_t vert_pix;
    // Even column held for the horizontal stage
    pool_pkg::pixel_t even_pix;
    pool_pkg::pooled_t pooled_q;

    // Unsigned maximum per channel
    function automatic pool_pkg::pixel_t pix_max(input pool_pkg::pixel_t a,
                                                 input pool_pkg::pixel_t b);
        pool_pkg::pixel_t res;
        pool_pkg::chan_t  ca;
        pool_pkg::chan_t  cb;
        res = '0;
        for (int c = 0; c < pool_pkg::NUM_CH; c++) begin
            ca = a[c*pool_pkg::CH_W +: pool_pkg::CH_W];
            cb = b[c*pool_pkg::CH_W +: pool_pkg::CH_W];
            res[c*pool_pkg::CH_W +: pool_pkg::CH_W] = (ca > cb) ? ca : cb;
        end
        return res;
    endfunction

    //====================================================================
    // Stage one, upper against lower
    //====================================================================
    always_ff @(posedge clk) begin
        if (areset) begin
            vert_valid <= 1'b0;
        end else begin
            vert_valid <= i_pair.valid;
        end
        vert_odd  <= i_pair.odd_col;
        vert_addr <= i_pair.out_addr;
        vert_pix  <= pix_max(i_pair.upper, i_pair.lower);
    end

    // Left half of the window, kept until its odd partner arrives
    always_ff @(posedge clk) begin
        if (vert_valid && !vert_odd) begin
            even_pix <= vert_pix;
        end
    end

    //====================================================================
    // Stage two, left column against right column
    //====================================================================
    always_ff @(posedge clk) begin
        if (areset) begin
            pooled_q.valid <= 1'b0;
        end else begin
            pooled_q.valid <= vert_valid && vert_odd;
        end
        pooled_q.out_addr <= vert_addr;
        pooled_q.pixel    <= pix_max(even_pix, vert_pix);
    end

    assign o_pooled = pooled_q;

endmodule

// File: logic/pool_row_buffer.sv
// Max-pool row buffer pairing each odd-row pixel with the stored pixel above it
`timescale 1ns/1ns

module pool_row_buffer (
    input  logic             clk,
    input  logic             areset,
    input  logic             i_start,
    input  logic             i_accept,
    input  logic             i_in_valid,
    input  pool_pkg::pixel_t i_pixel,
    output pool_pkg::pair_t  o_pair
);

    // Counter types sized from frame geometry
    typedef logic [pool_pkg::X_W-1:0] x_cnt_t;
    typedef logic [pool_pkg::Y_W-1:0] y_cnt_t;

    x_cnt_t           x_cnt;
    y_cnt_t           y_cnt;
    logic             beat;
    logic             x_last;
    logic             y_last;
    pool_pkg::addr_t  pair_addr;
    pool_pkg::pixel_t line_mem [pool_pkg::IMG_W];
    pool_pkg::pair_t  pair_q;

    //====================================================================
    // Raster position
    //====================================================================
    // Accepted input beat
    assign beat   = i_accept && i_in_valid;
    assign x_last = (x_cnt == x_cnt_t'(pool_pkg::IMG_W - 1));
    assign y_last = (y_cnt == y_cnt_t'(pool_pkg::IMG_H - 1));

    always_ff @(posedge clk) begin
        if (areset || i_start) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (beat) begin
            if (x_last) begin
                x_cnt <= '0;
                // Wrap at end of frame
                y_cnt <= y_last ? '0 : y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    //====================================================================
    // Line buffer
    //====================================================================
    // Even rows stored here and read back while the odd row streams in
    always_ff @(posedge clk) begin
        if (beat && !y_cnt[0]) begin
            line_mem[x_cnt] <= i_pixel;
        end
    end

    // Pooled raster index of the current window
    assign pair_addr = pool_pkg::addr_t'(y_cnt[pool_pkg::Y_W-1:1])
                     * pool_pkg::addr_t'(pool_pkg::OUT_W)
                     + pool_pkg::addr_t'(x_cnt[pool_pkg::X_W-1:1]);

    //====================================================================
    // Pair register
    //====================================================================
    always_ff @(posedge clk) begin
        if (areset) begin
            pair_q.valid <= 1'b0;
        end else begin
            pair_q.valid <= beat && y_cnt[0];
        end
        // Payload loads every cycle and is qualified by valid
        pair_q.upper    <= line_mem[x_cnt];
        pair_q.lower    <= i_pixel;
        pair_q.odd_col  <= x_cnt[0];
        pair_q.out_addr <= pair_addr;
    end

    assign o_pair = pair_q;

    // Outside a frame both counters rest at the origin
    a_cnt_rest: assert property (@(posedge clk) disable iff (areset)
        !i_accept |-> (x_cnt == '0) && (y_cnt == '0))
        else $error("row buffer counters ran past the frame");

endmodule

// File: logic/pool_frame_ctrl.sv
// Max-pool frame controller producing accept, start, idle, run, done and error status
`timescale 1ns/1ns

module pool_frame_ctrl (
    input  logic clk,
    input  logic areset,
    input  logic i_run,
    input  logic i_last_write,
    output logic o_idle,
    output logic o_run,
    output logic o_accept,
    output logic o_start,
    output logic o_done,
    output logic o_en_err
);

    pool_pkg::ctrl_state_e state_q;
    pool_pkg::ctrl_state_e state_d;
    logic                  en_err_q;

    //====================================================================
    // Frame FSM
    //====================================================================
    always_ff @(posedge clk) begin
        if (areset) begin
            state_q <= pool_pkg::S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            pool_pkg::S_IDLE: if (i_run) begin
                state_d = pool_pkg::S_RUN;
            end
            // Stay here until the final pooled word is written
            pool_pkg::S_RUN: if (i_last_write) begin
                state_d = pool_pkg::S_DONE;
            end
            // Back-to-back frame allowed from the done cycle
            pool_pkg::S_DONE: begin
                state_d = i_run ? pool_pkg::S_RUN : pool_pkg::S_IDLE;
            end
            default: state_d = pool_pkg::S_IDLE;
        endcase
    end

    // Sticky, run while a frame is in progress
    always_ff @(posedge clk) begin
        if (areset) begin
            en_err_q <= 1'b0;
        end else if (i_run && (state_q == pool_pkg::S_RUN)) begin
            en_err_q <= 1'b1;
        end
    end

    //====================================================================
    // Status outputs
    //====================================================================
    assign o_idle   = (state_q == pool_pkg::S_IDLE);
    assign o_run    = (state_q != pool_pkg::S_IDLE);
    assign o_accept = (state_q == pool_pkg::S_RUN);
    // Counters clear on the edge that enters S_RUN
    assign o_start  = (state_q != pool_pkg::S_RUN) && (state_d == pool_pkg::S_RUN);
    assign o_done   = (state_q == pool_pkg::S_DONE);
    assign o_en_err = en_err_q;

    // Done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (areset) o_done |=> !o_done)
        else $error("o_done held for more than one cycle");

endmodule

// File: logic/pool_pkg.sv
// Max-pool shared geometry, data types and controller state encoding
package pool_pkg;

    //====================================================================
    // Frame geometry
    //====================================================================
    // Input feature map size in pixels
    localparam int IMG_W = 8;
    localparam int IMG_H = 8;

    // Channels per pixel and bits per channel
    localparam int NUM_CH = 4;
    localparam int CH_W   = 8;

    // Pooled map, 2x2 window with stride 2
    localparam int OUT_W      = IMG_W / 2;
    localparam int OUT_H      = IMG_H / 2;
    localparam int POOL_WORDS = OUT_W * OUT_H;

    // Position counter and memory address widths
    localparam int X_W    = $clog2(IMG_W);
    localparam int Y_W    = $clog2(IMG_H);
    localparam int ADDR_W = $clog2(POOL_WORDS);

    //====================================================================
    // Data types
    //====================================================================
    typedef logic [CH_W-1:0]        chan_t;
    // Channel 0 in the low byte, also the memory data word
    typedef logic [NUM_CH*CH_W-1:0] pixel_t;
    typedef logic [ADDR_W-1:0]      addr_t;

    // Vertical pair from row buffer to comparator
    typedef struct packed {
        logic   valid;
        pixel_t upper;
        pixel_t lower;
        logic   odd_col;
        addr_t  out_addr;
    } pair_t;

    // One finished 2x2 window
    typedef struct packed {
        logic   valid;
        addr_t  out_addr;
        pixel_t pixel;
    } pooled_t;

    // Block RAM write port, no ready
    typedef struct packed {
        logic   ce;
        addr_t  addr;
        pixel_t data;
    } mem_wr_t;

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} ctrl_state_e;

endpackage
